// ==== logic/led_panel_defs.svh ====
`ifndef LED_PANEL_DEFS_SVH
`define LED_PANEL_DEFS_SVH

// number of LEDs in the external shift chain
`define LED_COUNT 16

// refresh period loaded at reset, in clk cycles
// lives in a 16-bit register field
`define LED_REFRESH_RESET 16'd1000

`endif

// ==== logic/led_panel_pkg.sv ====
`default_nettype none

`include "led_panel_defs.svh"

package led_panel_pkg;

    // register map of the host port
    typedef enum logic [1:0] {
        REG_PATTERN = 2'd0,  // led on/off pattern
        REG_BLINK   = 2'd1,  // blink mask
        REG_CTRL    = 2'd2,  // auto_en, active_low, refresh_req
        REG_PERIOD  = 2'd3   // auto refresh period
    } led_reg_addr_e;

    // serial shifter FSM
    typedef enum logic {
        SH_IDLE  = 1'b0,
        SH_SHIFT = 1'b1
    } shift_state_e;

    // configuration seen by the scheduler and the shifter
    typedef struct packed {
        logic [`LED_COUNT-1:0] pattern;
        logic [`LED_COUNT-1:0] blink_mask;
        logic                  auto_en;
        logic                  active_low;
        logic [15:0]           period;
    } led_cfg_t;

endpackage

`default_nettype wire

// ==== logic/led_reg_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_defs.svh"

module led_reg_block (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  led_panel_pkg::led_reg_addr_e addr,
    input  logic [15:0]                  wdata,
    output logic [15:0]                  rdata,
    output logic                         rd_valid,
    output led_panel_pkg::led_cfg_t      cfg,
    output logic                         refresh_req
);

    led_panel_pkg::led_cfg_t cfg_q;

    logic        wr_pattern;
    logic        wr_blink;
    logic        wr_ctrl;
    logic        wr_period;
    logic [15:0] rd_mux;

    // write decode
    assign wr_pattern = wr_en && (addr == led_panel_pkg::REG_PATTERN);
    assign wr_blink   = wr_en && (addr == led_panel_pkg::REG_BLINK);
    assign wr_ctrl    = wr_en && (addr == led_panel_pkg::REG_CTRL);
    assign wr_period  = wr_en && (addr == led_panel_pkg::REG_PERIOD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q.pattern    <= '0;
            cfg_q.blink_mask <= '0;
            cfg_q.auto_en    <= 1'b0;
            cfg_q.active_low <= 1'b0;
            cfg_q.period     <= `LED_REFRESH_RESET;
        end else begin
            if (wr_pattern) begin
                cfg_q.pattern <= wdata;
            end
            if (wr_blink) begin
                cfg_q.blink_mask <= wdata;
            end
            if (wr_ctrl) begin
                cfg_q.auto_en    <= wdata[0];
                cfg_q.active_low <= wdata[1];
            end
            if (wr_period) begin
                cfg_q.period <= wdata;
            end
        end
    end

    // request bit is a strobe, never stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refresh_req <= 1'b0;
        end else begin
            refresh_req <= wr_ctrl && wdata[2];
        end
    end

    always_comb begin
        case (addr)
            led_panel_pkg::REG_PATTERN: rd_mux = cfg_q.pattern;
            led_panel_pkg::REG_BLINK:   rd_mux = cfg_q.blink_mask;
            // bit 2 always reads back as zero
            led_panel_pkg::REG_CTRL:    rd_mux = {14'd0, cfg_q.active_low, cfg_q.auto_en};
            led_panel_pkg::REG_PERIOD:  rd_mux = cfg_q.period;
            default:                    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;  // answer one cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_mux;
        end
    end

    assign cfg = cfg_q;

endmodule

`default_nettype wire

// ==== logic/led_refresh_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_defs.svh"

module led_refresh_sched (
    input  logic                    clk,
    input  logic                    rst_n,
    input  led_panel_pkg::led_cfg_t cfg,
    input  logic                    refresh_req,
    input  logic                    finish,
    output logic [`LED_COUNT-1:0]   frame,
    output logic                    start
);

    logic [15:0]           per_cnt;
    logic [15:0]           per_last;
    logic                  per_tick;
    logic                  pending;
    logic                  phase;
    logic                  req_any;
    logic                  can_issue;
    logic                  issue;
    logic [`LED_COUNT-1:0] next_frame;

    // last count value of one period
    assign per_last = cfg.period - 16'd1;
    assign per_tick = cfg.auto_en && (per_cnt >= per_last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            per_cnt <= '0;
        end else if (!cfg.auto_en || per_tick) begin
            per_cnt <= '0;  // restart the period
        end else begin
            per_cnt <= per_cnt + 16'd1;
        end
    end

    // periodic, manual and held requests all collapse into one
    assign req_any = per_tick || refresh_req || pending;

    // start is still high in the cycle before the shifter drops finish,
    // so skip that cycle to keep the start a single pulse
    assign can_issue = finish && !start;
    assign issue     = req_any && can_issue;

    // phase 1 blanks the masked LEDs
    assign next_frame = phase ? (cfg.pattern & ~cfg.blink_mask) : cfg.pattern;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start   <= 1'b0;
            pending <= 1'b0;
            phase   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (issue) begin
                start   <= 1'b1;
                pending <= 1'b0;
                phase   <= ~phase;  // next frame uses the other phase
            end else if (req_any) begin
                pending <= 1'b1;  // shifter busy, hold one request
            end
        end
    end

    // frame stays stable until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            frame <= next_frame;
        end
    end

endmodule

`default_nettype wire

// ==== logic/led_serial_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_defs.svh"

module led_serial_shifter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`LED_COUNT-1:0] frame,
    input  logic                  active_low,
    output logic                  finish,
    output logic                  serial_clk,
    output logic                  serial_led
);

    localparam int CNT_W = $clog2(`LED_COUNT + 1);

    led_panel_pkg::shift_state_e state;

    logic                  start_q;
    logic                  start_edge;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  bit_phase;
    logic [`LED_COUNT-1:0] shreg;

    assign start_edge = start && !start_q;

    // count 0 is the load cycle, counts 1..16 carry data bits
    assign bit_phase = (state == led_panel_pkg::SH_SHIFT) && (bit_cnt != '0);

    assign finish = (state == led_panel_pkg::SH_IDLE);

    // rising edge of serial_clk lands mid-bit
    assign serial_clk = ~clk & bit_phase;

    // off level when no bit is on the line
    assign serial_led = active_low ^ (bit_phase & shreg[0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            state   <= led_panel_pkg::SH_IDLE;
            bit_cnt <= '0;
        end else begin
            start_q <= start;
            case (state)
                led_panel_pkg::SH_IDLE: begin
                    if (start_edge) begin
                        state   <= led_panel_pkg::SH_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                led_panel_pkg::SH_SHIFT: begin
                    if (bit_cnt == CNT_W'(`LED_COUNT)) begin
                        state   <= led_panel_pkg::SH_IDLE;  // last bit done
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state   <= led_panel_pkg::SH_IDLE;
                    bit_cnt <= '0;
                end
            endcase
        end
    end

    // lsb goes out first
    always_ff @(posedge clk) begin
        if ((state == led_panel_pkg::SH_IDLE) && start_edge) begin
            shreg <= frame;
        end else if (bit_phase) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/led_panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_defs.svh"

module led_panel_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  led_panel_pkg::led_reg_addr_e addr,
    input  logic [15:0]                  wdata,
    output logic [15:0]                  rdata,
    output logic                         rd_valid,
    output logic                         serial_clk,
    output logic                         serial_led,
    output logic                         finish
);

    led_panel_pkg::led_cfg_t cfg;
    logic                    refresh_req;
    logic [`LED_COUNT-1:0]   frame;
    logic                    start;

    led_reg_block u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rd_valid    (rd_valid),
        .cfg         (cfg),
        .refresh_req (refresh_req)
    );

    led_refresh_sched u_sched (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .refresh_req (refresh_req),
        .finish      (finish),
        .frame       (frame),
        .start       (start)
    );

    // polarity comes straight from the control register
    led_serial_shifter u_shifter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .frame      (frame),
        .active_low (cfg.active_low),
        .finish     (finish),
        .serial_clk (serial_clk),
        .serial_led (serial_led)
    );

endmodule

`default_nettype wire

// ==== verification/led_panel_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_defs.svh"

module led_panel_checker (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         wr_en,
    input logic                         rd_en,
    input led_panel_pkg::led_reg_addr_e addr,
    input logic [15:0]                  wdata,
    input logic [15:0]                  rdata,
    input logic                         rd_valid,
    input logic                         serial_clk,
    input logic                         serial_led,
    input logic                         finish
);

    // register and blink phase model
    logic [15:0]           m_pattern;
    logic [15:0]           m_blink;
    logic [15:0]           m_period;
    logic                  m_auto;
    logic                  m_low;
    logic                  m_phase;
    logic [15:0]           pat_d1;
    logic [15:0]           pat_d2;
    logic [15:0]           blk_d1;
    logic [15:0]           blk_d2;
    logic                  finish_q;
    logic                  rd_pend;
    logic [15:0]           rd_exp;
    logic [`LED_COUNT-1:0] exp_frame;
    logic [`LED_COUNT-1:0] cap;
    logic                  rise_ok;
    int                    cap_n = 0;
    int                    cycle = 0;
    int                    last_rise = 0;
    string                 cur_test = "none";
    int                    test_err0 = 0;
    int                    errors = 0;
    int                    frames = 0;
    int                    passed = 0;
    int                    failed = 0;

    function automatic logic [15:0] reg_value(input led_panel_pkg::led_reg_addr_e a);
        case (a)
            led_panel_pkg::REG_PATTERN: return m_pattern;
            led_panel_pkg::REG_BLINK:   return m_blink;
            led_panel_pkg::REG_CTRL:    return {14'd0, m_low, m_auto};  // request bit reads 0
            default:                    return m_period;
        endcase
    endfunction

    task note_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        errors = errors + 1;
    endtask

    task check_value(input string what, input logic [15:0] exp_v, input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    task begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task end_test();
        if (errors == test_err0) begin
            passed = passed + 1;
            $display("test %s: pass", cur_test);
        end else begin
            failed = failed + 1;
            $display("test %s: fail with %0d errors", cur_test, errors - test_err0);
        end
    endtask

    task check_frames(input int expected);
        check_value("frame count", 16'(expected), 16'(frames));
    endtask

    task check_idle();
        if (finish !== 1'b1) note_error("finish is not high while idle");
        if (serial_clk !== 1'b0) note_error("serial_clk toggles while idle");
        if (serial_led !== m_low) note_error("idle serial_led is not at the off level");
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            m_pattern = '0;
            m_blink   = '0;
            m_period  = `LED_REFRESH_RESET;
            m_auto    = 1'b0;
            m_low     = 1'b0;
            m_phase   = 1'b0;
            pat_d1    = '0;
            pat_d2    = '0;
            blk_d1    = '0;
            blk_d2    = '0;
            finish_q  = 1'b1;
            rd_pend   = 1'b0;
            rise_ok   = 1'b0;
            cap_n     = 0;
        end else begin
            cycle = cycle + 1;
            if (rd_pend) begin
                if (rd_valid !== 1'b1) note_error("rd_valid missing one cycle after a read");
                else check_value("read data", rd_exp, rdata);
            end else if (rd_valid !== 1'b0) begin
                note_error("rd_valid high without a read");
            end
            rd_pend = rd_en;
            if (rd_en) rd_exp = reg_value(addr);
            // frame was latched two edges before finish fell
            if (finish_q && !finish) begin
                exp_frame = m_phase ? (pat_d2 & ~blk_d2) : pat_d2;
                m_phase   = ~m_phase;
            end
            if (!finish_q && finish) begin
                if (rise_ok && m_auto && m_period >= 16'd20)
                    check_value("frame spacing", m_period, 16'(cycle - last_rise));
                last_rise = cycle;
                rise_ok   = m_auto;
            end
            finish_q = finish;
            pat_d2   = pat_d1;
            pat_d1   = m_pattern;
            blk_d2   = blk_d1;
            blk_d1   = m_blink;
            if (wr_en) begin
                case (addr)
                    led_panel_pkg::REG_PATTERN: m_pattern = wdata;
                    led_panel_pkg::REG_BLINK:   m_blink = wdata;
                    led_panel_pkg::REG_CTRL: begin
                        m_auto  = wdata[0];
                        m_low   = wdata[1];
                        rise_ok = 1'b0;  // spacing restarts
                    end
                    default: begin
                        m_period = wdata;
                        rise_ok  = 1'b0;
                    end
                endcase
            end
        end
    end

    // one bit per serial_clk rise with the lsb first
    always @(posedge serial_clk) begin
        cap   = {serial_led ^ m_low, cap[`LED_COUNT-1:1]};
        cap_n = cap_n + 1;
        if (cap_n == `LED_COUNT) begin
            check_value("frame bits", exp_frame, cap);
            frames = frames + 1;
            cap_n  = 0;
        end
    end

endmodule

`default_nettype wire

// ==== verification/led_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb;

    // cycle budgets per test
    localparam int T_READBACK     = 400;
    localparam int T_MANUAL       = 200;
    localparam int T_BLINK        = 200;
    localparam int T_POLARITY     = 200;
    localparam int T_AUTO         = 1500;
    localparam int T_BACKPRESSURE = 150;
    localparam int WATCHDOG_NS    = 2 * 8 * (T_READBACK + T_MANUAL + T_BLINK + T_POLARITY
                                             + T_AUTO + T_BACKPRESSURE);

    logic                         clk;
    logic                         rst_n;
    logic                         wr_en;
    logic                         rd_en;
    led_panel_pkg::led_reg_addr_e addr;
    logic [15:0]                  wdata;
    logic [15:0]                  rdata;
    logic                         rd_valid;
    logic                         serial_clk;
    logic                         serial_led;
    logic                         finish;
    logic [1:0]                   ctrl_bits;  // auto_en and active_low as last written

    always #4 clk = ~clk;

    led_panel_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .rd_valid   (rd_valid),
        .serial_clk (serial_clk),
        .serial_led (serial_led),
        .finish     (finish)
    );

    led_panel_checker u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .rd_valid   (rd_valid),
        .serial_clk (serial_clk),
        .serial_led (serial_led),
        .finish     (finish)
    );

    function automatic logic [15:0] rand16();
        int unsigned r;
        r = $urandom();
        return r[15:0];
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task write_reg(input led_panel_pkg::led_reg_addr_e a, input logic [15:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task read_reg(input led_panel_pkg::led_reg_addr_e a);
        rd_en = 1'b1;
        addr  = a;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task set_ctrl(input logic [1:0] bits);
        ctrl_bits = bits;
        write_reg(led_panel_pkg::REG_CTRL, {14'd0, bits});
    endtask

    task request_frame();
        write_reg(led_panel_pkg::REG_CTRL, {13'd0, 1'b1, ctrl_bits});
    endtask

    task wait_frames(input int target, input int limit);
        int n;
        n = 0;
        while (!(u_chk.frames >= target && finish === 1'b1) && n < limit) begin
            @(posedge clk);
            #1;
            n = n + 1;
        end
        if (n >= limit) u_chk.note_error("frame did not complete in time");
    endtask

    task wait_busy(input int limit);
        int n;
        n = 0;
        while (finish !== 1'b0 && n < limit) begin
            @(posedge clk);
            #1;
            n = n + 1;
        end
        if (n >= limit) u_chk.note_error("shifter never started the frame");
    endtask

    // idle for 4 cycles in a row means nothing is pending
    task drain();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 4 && n < 200) begin
            @(posedge clk);
            #1;
            n     = n + 1;
            quiet = (finish === 1'b1) ? quiet + 1 : 0;
        end
        if (quiet < 4) u_chk.note_error("shifter did not return to idle");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        int          n;
        int          per;
        logic [15:0] v;
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        addr      = led_panel_pkg::REG_PATTERN;
        wdata     = '0;
        ctrl_bits = 2'b00;
        void'($urandom(32'he753));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        u_chk.begin_test("readback");
        u_chk.check_idle();
        read_reg(led_panel_pkg::REG_PERIOD);  // reset period
        repeat (4) begin
            write_reg(led_panel_pkg::REG_PATTERN, rand16());
            write_reg(led_panel_pkg::REG_BLINK, rand16());
            write_reg(led_panel_pkg::REG_PERIOD, rand16());
            v = rand16();
            ctrl_bits = v[1:0];
            // request bit set so the readback of bit 2 means something
            write_reg(led_panel_pkg::REG_CTRL, {13'd0, 1'b1, v[1:0]});
            read_reg(led_panel_pkg::REG_PATTERN);
            read_reg(led_panel_pkg::REG_BLINK);
            read_reg(led_panel_pkg::REG_CTRL);
            read_reg(led_panel_pkg::REG_PERIOD);
            set_ctrl(2'b00);
            drain();
        end
        u_chk.end_test();

        u_chk.begin_test("manual");
        write_reg(led_panel_pkg::REG_BLINK, 16'h0000);
        repeat (4) begin
            write_reg(led_panel_pkg::REG_PATTERN, rand16());
            n = u_chk.frames;
            request_frame();
            wait_frames(n + 1, 60);
            drain();
            u_chk.check_frames(n + 1);
            u_chk.check_idle();
        end
        u_chk.end_test();

        u_chk.begin_test("blink");
        write_reg(led_panel_pkg::REG_BLINK, rand16());
        write_reg(led_panel_pkg::REG_PATTERN, rand16());
        repeat (4) begin
            n = u_chk.frames;
            request_frame();
            wait_frames(n + 1, 60);
            drain();
        end
        u_chk.end_test();

        u_chk.begin_test("polarity");
        set_ctrl(2'b10);
        drain();
        u_chk.check_idle();
        repeat (3) begin
            write_reg(led_panel_pkg::REG_PATTERN, rand16());
            n = u_chk.frames;
            request_frame();
            wait_frames(n + 1, 60);
            drain();
            u_chk.check_idle();
        end
        set_ctrl(2'b00);
        drain();
        u_chk.end_test();

        u_chk.begin_test("auto refresh");
        v   = rand16();
        per = 20 + (v % 200);
        write_reg(led_panel_pkg::REG_PERIOD, 16'(per));
        n = u_chk.frames;
        set_ctrl(2'b01);
        wait_frames(n + 5, 6 * per + 60);
        set_ctrl(2'b00);
        drain();
        u_chk.end_test();

        u_chk.begin_test("back-pressure");
        n = u_chk.frames;
        write_reg(led_panel_pkg::REG_PATTERN, rand16());
        request_frame();
        wait_busy(10);
        repeat (3) request_frame();
        write_reg(led_panel_pkg::REG_PATTERN, rand16());  // lands in the next frame
        wait_frames(n + 2, 80);
        drain();
        u_chk.check_frames(n + 2);
        u_chk.end_test();

        $display("tests passed %0d, failed %0d, errors %0d",
                 u_chk.passed, u_chk.failed, u_chk.errors);
        if (u_chk.failed == 0 && u_chk.errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== led_panel.f ====
+incdir+logic
logic/led_panel_pkg.sv
logic/led_reg_block.sv
logic/led_refresh_sched.sv
logic/led_serial_shifter.sv
logic/led_panel_top.sv
verification/led_panel_checker.sv
verification/led_panel_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f led_panel.f --top-module led_panel_tb \
		-o led_panel_sim

# the pass line decides the exit status
run: compile
	./obj_dir/led_panel_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null

clean:
	rm -rf obj_dir
